// ==== Bender.yml ====
package:
  name: mem_system

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cache_pkg.sv
      - verilog/cache_way.sv
      - verilog/four_bank_mem.sv
      - verilog/cache_cntrl_assoc.sv
      - verilog/mem_system.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_mem_system.sv

// ==== filelist.f ====
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_way.sv
verilog/four_bank_mem.sv
verilog/cache_cntrl_assoc.sv
verilog/mem_system.sv
tests/tb_mem_system.sv

// ==== tests/tb_mem_system.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_settings.svh"

module tb_mem_system;

    localparam int TIMEOUT  = 40;
    localparam int N_RANDOM = 300;
    localparam int SETS     = 1 << `CACHE_INDEX_W;

    logic             clk;
    logic             arst_n;
    cache_pkg::addr_t addr;
    cache_pkg::data_t data_in;
    logic             rd;
    logic             wr;
    cache_pkg::data_t data_out;
    logic             done;
    logic             stall;
    logic             cache_hit;

    // expected response of the request in flight
    logic             exp_hit;
    int               exp_cyc;
    cache_pkg::data_t exp_data;
    int               cyc;

    // reference model: memory contents plus per-set way state
    cache_pkg::data_t shadow  [`MEM_WORDS];
    cache_pkg::tag_t  m_tag   [2][SETS];
    logic             m_valid [2][SETS];
    logic             m_dirty [2][SETS];
    logic             m_victim;
    logic [15:0]      lfsr;

    mem_system dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .addr      (addr),
        .data_in   (data_in),
        .rd        (rd),
        .wr        (wr),
        .data_out  (data_out),
        .done      (done),
        .stall     (stall),
        .cache_hit (cache_hit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // cycle number since acceptance, steady over each rising edge
    always @(negedge clk) begin
        if (stall) begin
            cyc <= cyc + 1;
        end else begin
            cyc <= 0;
        end
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        abort_run($sformatf("Fail %0t ns: %s", $time, msg));
    endtask

    a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !stall && !done && !cache_hit)
        else report_mismatch("stall, done or cache_hit active during reset");
    a_done_stalled: assert property (@(posedge clk) disable iff (!arst_n) done |-> stall)
        else report_mismatch("done without stall");
    a_hit_in_done: assert property (@(posedge clk) disable iff (!arst_n) cache_hit |-> done)
        else report_mismatch("cache_hit outside the done cycle");
    a_stall_holds: assert property (@(posedge clk) disable iff (!arst_n)
        stall && !done |=> stall)
        else report_mismatch("stall dropped before done");
    a_stall_release: assert property (@(posedge clk) disable iff (!arst_n) done |=> !stall)
        else report_mismatch("stall still high in idle after done");
    a_accept: assert property (@(posedge clk) disable iff (!arst_n)
        !stall && (rd || wr) |=> stall)
        else report_mismatch("no stall in the cycle after acceptance");
    a_latency: assert property (@(posedge clk) disable iff (!arst_n) done |-> cyc == exp_cyc)
        else report_mismatch($sformatf("done in cycle %0d, expected %0d", cyc, exp_cyc));
    a_hit_pred: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> cache_hit == exp_hit)
        else report_mismatch($sformatf("cache_hit wrong at %h, expected %b", addr, exp_hit));
    a_read_data: assert property (@(posedge clk) disable iff (!arst_n)
        done && rd |-> data_out == exp_data)
        else report_mismatch($sformatf("read of %h wrong, expected %h", addr, exp_data));

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    // sets the expected values, then moves the model past the request
    task automatic predict(input logic is_wr, input cache_pkg::addr_t a,
                           input cache_pkg::data_t d);
        cache_pkg::tag_t   t;
        cache_pkg::index_t idx;
        int                hw;
        int                vw;
        t   = a[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
        idx = a[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
        hw  = -1;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == t) begin
                hw = w;
            end
        end
        // one victim bit for the whole cache, flips on every request
        m_victim = ~m_victim;
        if (hw >= 0) begin
            exp_hit = 1'b1;
            exp_cyc = 2;
            if (is_wr) begin
                m_dirty[hw][idx] = 1'b1;
            end
        end else begin
            vw      = !m_valid[0][idx] ? 0 : (!m_valid[1][idx] ? 1 : int'(m_victim));
            exp_hit = 1'b0;
            exp_cyc = (m_valid[vw][idx] && m_dirty[vw][idx]) ? 11 : 7;
            m_tag[vw][idx]   = t;
            m_valid[vw][idx] = 1'b1;
            m_dirty[vw][idx] = is_wr;
        end
        if (is_wr) begin
            shadow[a[`CACHE_ADDR_W-1:1]] = d;
        end
        exp_data = shadow[a[`CACHE_ADDR_W-1:1]];
    endtask

    task automatic access(input logic is_wr, input cache_pkg::addr_t a,
                          input cache_pkg::data_t d);
        int n;
        predict(is_wr, a, d);
        addr    = a;
        data_in = d;
        wr      = is_wr;
        rd      = ~is_wr;
        n       = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!done && n < TIMEOUT);
        if (!done) begin
            abort_run($sformatf("timeout: no done within %0d cycles for address %h", TIMEOUT, a));
        end
        // request stays up over the done edge
        @(negedge clk);
        rd = 1'b0;
        wr = 1'b0;
        // one idle cycle between requests
        @(negedge clk);
    endtask

    initial begin
        logic [15:0]     v_op;
        logic [15:0]     v_tag;
        logic [15:0]     v_idx;
        logic [15:0]     v_word;
        logic [15:0]     v_data;
        cache_pkg::tag_t pool [4];
        arst_n   = 1'b0;
        rd       = 1'b0;
        wr       = 1'b0;
        addr     = '0;
        data_in  = '0;
        exp_hit  = 1'b0;
        exp_cyc  = 0;
        exp_data = '0;
        lfsr     = 16'd5;
        m_victim = 1'b0;
        pool     = '{5'h01, 5'h06, 5'h0d, 5'h16};
        for (int i = 0; i < `MEM_WORDS; i++) begin
            shadow[i] = '0;
        end
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                m_tag[w][s]   = '0;
                m_valid[w][s] = 1'b0;
                m_dirty[w][s] = 1'b0;
            end
        end
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // untouched address
        access(1'b0, {5'h09, 8'h80, 3'b010}, '0);
        // three tags in one set force dirty evictions
        access(1'b1, {pool[0], 8'h40, 3'b000}, 16'h1111);
        access(1'b1, {pool[1], 8'h40, 3'b010}, 16'h2222);
        access(1'b1, {pool[2], 8'h40, 3'b100}, 16'h3333);
        access(1'b0, {pool[0], 8'h40, 3'b000}, '0);
        access(1'b0, {pool[1], 8'h40, 3'b010}, '0);
        access(1'b0, {pool[2], 8'h40, 3'b100}, '0);

        for (int i = 0; i < N_RANDOM; i++) begin
            take_bits(1, v_op);
            take_bits(2, v_tag);
            take_bits(3, v_idx);
            take_bits(2, v_word);
            take_bits(16, v_data);
            access(v_op[0], {pool[v_tag[1:0]], 5'b0, v_idx[2:0], v_word[1:0], 1'b0}, v_data);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/cache_cntrl_assoc.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_settings.svh"

module cache_cntrl_assoc (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire cache_pkg::addr_t    addr,
    input  wire cache_pkg::data_t    data_in,
    input  wire                      rd,
    input  wire                      wr,
    input  wire cache_pkg::way_rsp_t way0_rsp,
    input  wire cache_pkg::way_rsp_t way1_rsp,
    output cache_pkg::way_req_t      way0_req,
    output cache_pkg::way_req_t      way1_req,
    output cache_pkg::mem_req_t      mem_req,
    input  wire cache_pkg::data_t    mem_data,
    output cache_pkg::data_t         data_out,
    output logic                     done,
    output logic                     stall,
    output logic                     cache_hit
);

    cache_pkg::cntrl_state_e state;
    cache_pkg::cntrl_state_e nxt_state;
    cache_pkg::tag_t         req_tag;
    cache_pkg::index_t       req_index;
    cache_pkg::offset_t      req_offset;
    cache_pkg::way_req_t     way_req;
    cache_pkg::way_rsp_t     vict_rsp;
    cache_pkg::data_t        data_q;

    logic       accept;
    logic       hit0;
    logic       hit1;
    logic       any_hit;
    logic       vict_way;
    logic       vict_dirty;
    logic       victim_q;
    logic       way_sel;
    logic       op_wr;
    logic       way_wr;
    logic       wr_way;
    logic       fill_wr;
    logic       fill_match;
    logic       rd_capture;
    logic [1:0] wb_word;
    logic [1:0] rd_word;
    logic [1:0] fill_word;

    assign req_tag    = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign req_index  = addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign req_offset = addr[`CACHE_OFFSET_W-1:0];

    assign accept = (state == cache_pkg::idle) && (rd || wr);

    assign hit0    = way0_rsp.hit & way0_rsp.valid;
    assign hit1    = way1_rsp.hit & way1_rsp.valid;
    assign any_hit = hit0 | hit1;

    // invalid way wins, way 0 first; else the victim bit
    assign vict_way   = !way0_rsp.valid ? 1'b0 : (!way1_rsp.valid ? 1'b1 : victim_q);
    assign vict_dirty = vict_way ? (way1_rsp.valid & way1_rsp.dirty)
                                 : (way0_rsp.valid & way0_rsp.dirty);
    assign vict_rsp   = way_sel ? way1_rsp : way0_rsp;

    // word numbers follow the state order
    assign wb_word    = 2'(state - cache_pkg::wb_0);
    assign rd_word    = 2'(state - cache_pkg::fill_0);
    assign fill_word  = 2'(state - cache_pkg::fill_2);
    assign fill_match = (fill_word == req_offset[`CACHE_OFFSET_W-1:1]);
    assign rd_capture = fill_wr & ~op_wr & fill_match;

    always_comb begin
        nxt_state      = state;
        way_req        = '0;
        way_req.index  = req_index;
        way_req.tag    = req_tag;
        way_req.offset = req_offset;
        way_req.data   = data_in;
        way_wr         = 1'b0;
        wr_way         = 1'b0;
        fill_wr        = 1'b0;
        mem_req        = '0;
        done           = 1'b0;
        stall          = 1'b1;
        cache_hit      = 1'b0;

        case (state)
            cache_pkg::idle: begin
                stall = 1'b0;
                if (accept) begin
                    nxt_state = rd ? cache_pkg::comp_rd : cache_pkg::comp_wr;
                end
            end
            cache_pkg::comp_rd, cache_pkg::comp_wr: begin
                way_req.enable = 1'b1;
                way_req.comp   = 1'b1;
                // write hit goes only to the matching way
                way_wr = (state == cache_pkg::comp_wr) & any_hit;
                wr_way = hit1;
                if (any_hit) begin
                    nxt_state = cache_pkg::done;
                end else if (vict_dirty) begin
                    nxt_state = cache_pkg::wb_0;
                end else begin
                    nxt_state = cache_pkg::fill_0;
                end
            end
            cache_pkg::wb_0, cache_pkg::wb_1, cache_pkg::wb_2, cache_pkg::wb_3: begin
                way_req.enable = 1'b1;
                way_req.offset = {wb_word, 1'b0};
                mem_req.wr     = 1'b1;
                mem_req.addr   = {vict_rsp.tag, req_index, wb_word, 1'b0};
                mem_req.data   = vict_rsp.data;
                nxt_state      = cache_pkg::cntrl_state_e'(state + 1);
            end
            cache_pkg::fill_0, cache_pkg::fill_1, cache_pkg::fill_2,
            cache_pkg::fill_3, cache_pkg::fill_4, cache_pkg::fill_5: begin
                if (state <= cache_pkg::fill_3) begin
                    mem_req.rd   = 1'b1;
                    mem_req.addr = {req_tag, req_index, rd_word, 1'b0};
                end
                // returning words land MEM_LATENCY cycles later
                if (state >= cache_pkg::fill_2) begin
                    fill_wr          = 1'b1;
                    way_wr           = 1'b1;
                    wr_way           = way_sel;
                    way_req.enable   = 1'b1;
                    way_req.valid_in = 1'b1;
                    way_req.offset   = {fill_word, 1'b0};
                    way_req.data     = (op_wr && fill_match) ? data_in : mem_data;
                end
                if (state == cache_pkg::fill_5) begin
                    // last word as compare write so a write miss leaves the line dirty
                    way_req.comp = op_wr;
                    done         = 1'b1;
                    nxt_state    = cache_pkg::idle;
                end else begin
                    nxt_state = cache_pkg::cntrl_state_e'(state + 1);
                end
            end
            cache_pkg::done: begin
                done      = 1'b1;
                cache_hit = 1'b1;
                nxt_state = cache_pkg::idle;
            end
            default: begin
                nxt_state = cache_pkg::idle;
            end
        endcase
    end

    always_comb begin
        way0_req       = way_req;
        way1_req       = way_req;
        way0_req.write = way_wr & ~wr_way;
        way1_req.write = way_wr & wr_way;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= cache_pkg::idle;
            victim_q <= 1'b0;
            way_sel  <= 1'b0;
            op_wr    <= 1'b0;
        end else begin
            state <= nxt_state;
            if (accept) begin
                victim_q <= ~victim_q;
                op_wr    <= ~rd;
            end
            if (state == cache_pkg::comp_rd || state == cache_pkg::comp_wr) begin
                way_sel <= vict_way;
            end
        end
    end

    // read word holder
    always_ff @(posedge clk) begin
        if (state == cache_pkg::comp_rd) begin
            data_q <= hit1 ? way1_rsp.data : way0_rsp.data;
        end else if (rd_capture) begin
            data_q <= mem_data;
        end
    end

    // last fill word is passed straight through
    assign data_out = rd_capture ? mem_data : data_q;

endmodule

`default_nettype wire

// ==== verilog/cache_pkg.sv ====
`default_nettype none

`include "cache_settings.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_W-1:0]   addr_t;
    typedef logic [`CACHE_DATA_W-1:0]   data_t;
    typedef logic [`CACHE_TAG_W-1:0]    tag_t;
    typedef logic [`CACHE_INDEX_W-1:0]  index_t;
    typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

    // controller to way
    typedef struct packed {
        logic    enable;
        logic    comp;
        logic    write;
        logic    valid_in;
        index_t  index;
        offset_t offset;
        tag_t    tag;
        data_t   data;
    } way_req_t;

    // way to controller
    typedef struct packed {
        logic  hit;
        logic  dirty;
        logic  valid;
        tag_t  tag;
        data_t data;
    } way_rsp_t;

    typedef struct packed {
        logic  wr;
        logic  rd;
        addr_t addr;
        data_t data;
    } mem_req_t;

    // order matters, the controller derives word numbers from it
    typedef enum logic [3:0] {
        idle, comp_rd, comp_wr,
        wb_0, wb_1, wb_2, wb_3,
        fill_0, fill_1, fill_2, fill_3, fill_4, fill_5,
        done
    } cntrl_state_e;

endpackage

`default_nettype wire

// ==== verilog/cache_settings.svh ====
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// address split: tag | index | byte offset
`define CACHE_ADDR_W    16
`define CACHE_DATA_W    16
`define CACHE_TAG_W     5
`define CACHE_INDEX_W   8
`define CACHE_OFFSET_W  3

// main memory
`define MEM_WORDS       32768
// cycles from read strobe to data on the bus
`define MEM_LATENCY     2

`endif

// ==== verilog/cache_way.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_settings.svh"

module cache_way (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire cache_pkg::way_req_t req,
    output cache_pkg::way_rsp_t      rsp
);

    localparam int LINES = 1 << `CACHE_INDEX_W;
    // two bytes per word
    localparam int WORDS = 1 << (`CACHE_OFFSET_W - 1);

    cache_pkg::tag_t  tag_mem  [LINES];
    cache_pkg::data_t data_mem [LINES][WORDS];

    logic [LINES-1:0]           valid_q;
    logic [LINES-1:0]           dirty_q;
    logic [`CACHE_OFFSET_W-2:0] word_sel;
    logic                       tag_match;
    logic                       wr_hit;
    logic                       wr_fill;

    assign word_sel  = req.offset[`CACHE_OFFSET_W-1:1];
    assign tag_match = (tag_mem[req.index] == req.tag);

    always_comb begin
        rsp.hit   = req.enable & req.comp & tag_match;
        rsp.dirty = dirty_q[req.index];
        rsp.valid = valid_q[req.index];
        rsp.tag   = tag_mem[req.index];
        rsp.data  = data_mem[req.index][word_sel];
    end

    // compare write only lands on a valid matching line
    assign wr_hit  = req.enable & req.write & req.comp & tag_match & valid_q[req.index];
    // fill from memory, no compare
    assign wr_fill = req.enable & req.write & ~req.comp & req.valid_in;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_fill) begin
            valid_q[req.index] <= 1'b1;
            dirty_q[req.index] <= 1'b0;
        end else if (wr_hit) begin
            dirty_q[req.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fill) begin
            tag_mem[req.index] <= req.tag;
        end
        if (wr_fill || wr_hit) begin
            data_mem[req.index][word_sel] <= req.data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/four_bank_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_settings.svh"

module four_bank_mem (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire cache_pkg::mem_req_t req,
    output cache_pkg::data_t         rdata
);

    localparam int BANKS = 4;
    localparam int ROWS  = `MEM_WORDS / BANKS;
    localparam int ROW_W = $clog2(ROWS);
    localparam int LAST  = `MEM_LATENCY - 1;

    logic [1:0]             bank_sel;
    logic [ROW_W-1:0]       row_sel;
    logic [`MEM_LATENCY-1:0] pipe_vld;
    logic [1:0]             pipe_bank [`MEM_LATENCY];
    logic [ROW_W-1:0]       pipe_row  [`MEM_LATENCY];
    cache_pkg::data_t       bank_rd   [BANKS];

    // word interleave: address bit 0 is the byte, bits 2:1 the bank
    assign bank_sel = req.addr[2:1];
    assign row_sel  = req.addr[ROW_W+2:3];

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        cache_pkg::data_t mem [ROWS];

        // contents start out zeroed
        initial begin
            for (int i = 0; i < ROWS; i++) begin
                mem[i] = '0;
            end
        end

        always_ff @(posedge clk) begin
            if (req.wr && (bank_sel == 2'(b))) begin
                mem[row_sel] <= req.data;
            end
        end

        // read at the tail of the pipeline
        assign bank_rd[b] = mem[pipe_row[LAST]];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pipe_vld <= '0;
        end else begin
            pipe_vld <= {pipe_vld[`MEM_LATENCY-2:0], req.rd};
        end
    end

    // bank and row travel with each read in flight
    always_ff @(posedge clk) begin
        pipe_bank[0] <= bank_sel;
        pipe_row[0]  <= row_sel;
        for (int s = 1; s < `MEM_LATENCY; s++) begin
            pipe_bank[s] <= pipe_bank[s-1];
            pipe_row[s]  <= pipe_row[s-1];
        end
    end

    assign rdata = pipe_vld[LAST] ? bank_rd[pipe_bank[LAST]] : '0;

endmodule

`default_nettype wire

// ==== verilog/mem_system.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_system (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire cache_pkg::addr_t addr,
    input  wire cache_pkg::data_t data_in,
    input  wire                   rd,
    input  wire                   wr,
    output wire cache_pkg::data_t data_out,
    output wire                   done,
    output wire                   stall,
    output wire                   cache_hit
);

    cache_pkg::way_req_t way0_req;
    cache_pkg::way_req_t way1_req;
    cache_pkg::way_rsp_t way0_rsp;
    cache_pkg::way_rsp_t way1_rsp;
    cache_pkg::mem_req_t mem_req;
    cache_pkg::data_t    mem_data;

    cache_cntrl_assoc u_cntrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .addr      (addr),
        .data_in   (data_in),
        .rd        (rd),
        .wr        (wr),
        .way0_rsp  (way0_rsp),
        .way1_rsp  (way1_rsp),
        .way0_req  (way0_req),
        .way1_req  (way1_req),
        .mem_req   (mem_req),
        .mem_data  (mem_data),
        .data_out  (data_out),
        .done      (done),
        .stall     (stall),
        .cache_hit (cache_hit)
    );

    cache_way u_way0 (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (way0_req),
        .rsp    (way0_rsp)
    );

    cache_way u_way1 (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (way1_req),
        .rsp    (way1_rsp)
    );

    four_bank_mem u_mem (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (mem_req),
        .rdata  (mem_data)
    );

endmodule

`default_nettype wire
